// ==== qed_mem_rf_tests.txt ====
# op arg1 arg2 in hex: W addr data, R addr expected rdata, P enable_b, I isol_en
R 0 0
R 1 0
R 2 0
R 3 0
R 4 0
R 5 0
R 6 0
R 7 0
W 0 10000111122223333444455556666777788889999aaaa
W 1 0deadbeefcafef00d123456789abcdef00f1e2d3c4b5a
W 2 1ffffffffffffffffffffffffffffffffffffffffffff
W 3 0a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
W 4 15a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
W 5 00001000200030004000500060007000800090000a000b
W 6 180008000800080008000800080008000800080000001
W 7 076543210fedcba9876543210fedcba9876543210fedc
W 5 1c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3
R 0 10000111122223333444455556666777788889999aaaa
R 1 0deadbeefcafef00d123456789abcdef00f1e2d3c4b5a
R 2 1ffffffffffffffffffffffffffffffffffffffffffff
R 3 0a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
R 4 15a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
R 5 1c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3
R 6 180008000800080008000800080008000800080000001
R 7 076543210fedcba9876543210fedcba9876543210fedc
I 1
R 2 0
I 0
R 2 1ffffffffffffffffffffffffffffffffffffffffffff
P 1
W 3 1f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0
P 0
R 0 0
R 3 0
W 3 024682468246824682468246824682468246824682468
R 3 024682468246824682468246824682468246824682468

// ==== build.f ====
mem_pkg.sv
pwr_pkg.sv
mem_reset_sync.sv
mem_pg_seq.sv
rf_8x178_array.sv
qed_mem_rf_pg_8x177.sv
qed_mem_rf_assertions.sv
tb_qed_mem_rf.sv

// ==== Makefile ====
# Verilator build and run of the register-file testbench

SIM := obj_dir/Vtb_qed_mem_rf

# Rebuilt only when the file list or a listed source changes
$(SIM): build.f $(shell cat build.f)
	verilator --binary --timing --assert --top-module tb_qed_mem_rf -Mdir obj_dir -f build.f

.PHONY: run clean

# The error limit lets assertion failures be counted instead of ending the run
run: $(SIM)
	@out=$$(./$(SIM) +verilator+error+limit+1000); echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

// ==== tb_qed_mem_rf.sv ====
//------------------------------------------------
// Testbench for the power-gated 8x177 register file
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_qed_mem_rf;

    import mem_pkg::*;
    import pwr_pkg::*;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  fscan_rstbypen;
    logic                  fscan_byprst_b;
    mem_wr_t               wr;
    mem_rd_t               rd;
    pwr_ctl_t              pwr;
    logic [mem_data_w-1:0] rdata;
    logic                  pwr_enable_b_out;

    // Test lines as parsed, arg_a holds the address or the level
    string                 op_q[$];
    logic [mem_data_w-1:0] arg_a_q[$];
    logic [mem_data_w-1:0] arg_b_q[$];

    int errors      = 0;
    int checks      = 0;
    int sva_fails   = 0;
    int cycles      = 0;
    int cycle_limit = 0;

    // One 10 ns clock feeds both the write and the read domain
    always #5 clk = ~clk;

    qed_mem_rf_pg_8x177 dut0 (
         .wclk             (clk)
        ,.rclk             (clk)
        ,.arst_n           (arst_n)
        ,.fscan_rstbypen   (fscan_rstbypen)
        ,.fscan_byprst_b   (fscan_byprst_b)
        ,.wr               (wr)
        ,.rd               (rd)
        ,.rdata            (rdata)
        ,.pwr              (pwr)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // Watchdog, armed once the test file is loaded
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------
    // Test file and operations
    // ------------------------------------------------

    // A line is an op and one or two hex values, # starts a comment line
    task automatic load_tests();
        int                    fd;
        int                    n;
        int                    want;
        string                 op;
        string                 rest;
        logic [mem_data_w-1:0] a;
        logic [mem_data_w-1:0] b;
        fd = $fopen("qed_mem_rf_tests.txt", "r");
        if (fd == 0) begin
            $display("The test file qed_mem_rf_tests.txt could not be opened");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                a = '0;
                b = '0;
                if (op == "#") begin
                    n = $fgets(rest, fd);
                end else begin
                    // W and R carry a second value, P and I only a level
                    want = (op == "W" || op == "R") ? 2 : 1;
                    if (want == 2) begin
                        n = $fscanf(fd, "%h %h", a, b);
                    end else begin
                        n = $fscanf(fd, "%h", a);
                    end
                    if (n != want) begin
                        $display("Test line %0d (%s) is missing a value", op_q.size() + 1, op);
                        errors++;
                    end
                    op_q.push_back(op);
                    arg_a_q.push_back(a);
                    arg_b_q.push_back(b);
                end
            end
            $fclose(fd);
        end
    endtask

    // One-cycle write strobe, taken by the array on the next edge
    task automatic write_entry(input logic [mem_addr_w-1:0] addr,
                               input logic [mem_data_w-1:0] data);
        @(posedge clk);
        wr <= '{en: 1'b1, addr: addr, data: data};
        @(posedge clk);
        wr <= '0;
    endtask

    // rdata is looked at half a cycle after the edge that took the strobe
    task automatic read_check(input logic [mem_addr_w-1:0] addr,
                              input logic [mem_data_w-1:0] expected);
        @(posedge clk);
        rd <= '{en: 1'b1, addr: addr};
        @(posedge clk);
        rd <= '0;
        @(negedge clk);
        checks++;
        assert (rdata === expected) else begin
            errors++;
            $display("ERROR: %0t ns: entry %0d read %h, expected %h",
                     $time, addr, rdata, expected);
        end
    endtask

    // Change enable_b, wait for the acknowledge and let the write side settle
    task automatic set_power(input logic level);
        @(posedge clk);
        pwr.enable_b <= level;
        while (pwr_enable_b_out !== level) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic set_isolation(input logic level);
        @(posedge clk);
        pwr.isol_en <= level;
    endtask

    // Random pause of 0 to 3 cycles
    task automatic idle_gap();
        repeat ($urandom % 4) @(posedge clk);
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------

    initial begin
        void'($urandom(32'hdfda_a42c));
        arst_n         = 1'b0;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;
        wr             = '0;
        rd             = '0;
        pwr            = '0;
        load_tests();
        cycle_limit = 20 * op_q.size() + 100;

        // Four cycles in reset, then room for both synchronizers to release
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) @(posedge clk);

        foreach (op_q[i]) begin
            if (op_q[i] == "W") begin
                write_entry(arg_a_q[i][mem_addr_w-1:0], arg_b_q[i]);
            end else if (op_q[i] == "R") begin
                read_check(arg_a_q[i][mem_addr_w-1:0], arg_b_q[i]);
            end else if (op_q[i] == "I") begin
                set_isolation(arg_a_q[i][0]);
            end else if (op_q[i] == "P") begin
                set_power(arg_a_q[i][0]);
            end else begin
                $display("Test line %0d has an unknown operation %s", i + 1, op_q[i]);
                errors++;
            end
            if (op_q[i] != "P") begin
                idle_gap();
            end
        end

        sva_fails = dut0.i_sva.ack_rise_fails + dut0.i_sva.ack_fall_fails
                  + dut0.i_sva.isol_fails + dut0.i_sva.reset_fails;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, sva_fails);
        if (errors == 0 && sva_fails == 0 && checks > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== qed_mem_rf_assertions.sv ====
//------------------------------------------------
// Acknowledge, isolation and reset checks bound
// to the register-file top level
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module qed_mem_rf_assertions (
     input logic                           rclk
    ,input logic                           rrst_n
    ,input pwr_pkg::pwr_ctl_t              pwr
    ,input logic [mem_pkg::mem_data_w-1:0] rdata
    ,input logic                           pwr_enable_b_out
);

    import pwr_pkg::*;

    // Failure count of each property below
    int ack_rise_fails = 0;
    int ack_fall_fails = 0;
    int isol_fails     = 0;
    int reset_fails    = 0;

    // The sequencer changes the acknowledge pg_ack_dly edges after it
    // samples enable_b, so the sampled view sees it one edge later
    ack_rise_a : assert property (@(posedge rclk) disable iff (!rrst_n)
        $rose(pwr.enable_b) && !pwr_enable_b_out
        |-> ##pg_ack_dly !pwr_enable_b_out ##1 pwr_enable_b_out)
        else begin
            $error("pwr_enable_b_out did not rise %0d cycles after enable_b", pg_ack_dly);
            ack_rise_fails++;
        end

    ack_fall_a : assert property (@(posedge rclk) disable iff (!rrst_n)
        $fell(pwr.enable_b) && pwr_enable_b_out
        |-> ##pg_ack_dly pwr_enable_b_out ##1 !pwr_enable_b_out)
        else begin
            $error("pwr_enable_b_out did not fall %0d cycles after enable_b", pg_ack_dly);
            ack_fall_fails++;
        end

    // The clamp is combinational, so it holds at every sampled edge
    isol_a : assert property (@(posedge rclk) pwr.isol_en |-> rdata == '0)
        else begin
            $error("rdata is not zero while isolation is on");
            isol_fails++;
        end

    reset_a : assert property (@(posedge rclk) $rose(rrst_n) |-> !pwr_enable_b_out)
        else begin
            $error("pwr_enable_b_out is high when the read reset releases");
            reset_fails++;
        end

endmodule

bind qed_mem_rf_pg_8x177 qed_mem_rf_assertions i_sva (
     .rclk             (rclk)
    ,.rrst_n           (rrst_n)
    ,.pwr              (pwr)
    ,.rdata            (rdata)
    ,.pwr_enable_b_out (pwr_enable_b_out)
);

`default_nettype wire

// ==== qed_mem_rf_pg_8x177.sv ====
//------------------------------------------------
// Power-gated 8x177 register file, top level
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module qed_mem_rf_pg_8x177 (
     input  logic                            wclk
    ,input  logic                            rclk
    ,input  logic                            arst_n
    ,input  logic                            fscan_rstbypen
    ,input  logic                            fscan_byprst_b

    // Request ports, wr on wclk, rd on rclk
    ,input  mem_pkg::mem_wr_t                wr
    ,input  mem_pkg::mem_rd_t                rd
    ,output logic [mem_pkg::mem_data_w-1:0]  rdata

    // Power-manager interface, rclk domain
    ,input  pwr_pkg::pwr_ctl_t               pwr
    ,output logic                            pwr_enable_b_out
);

    // Per-domain resets and the array power state
    logic wrst_n;
    logic rrst_n;
    logic mem_on;

    // ------------------------------------------------
    // Reset synchronizers, one per clock domain
    // ------------------------------------------------

    mem_reset_sync i_wrst_sync (
         .clk            (wclk)
        ,.arst_n         (arst_n)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rst_n_sync     (wrst_n)
    );

    mem_reset_sync i_rrst_sync (
         .clk            (rclk)
        ,.arst_n         (arst_n)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rst_n_sync     (rrst_n)
    );

    // ------------------------------------------------
    // Power-gate sequencer
    // ------------------------------------------------

    // Runs on the read clock, as the power manager does
    mem_pg_seq i_pg_seq (
         .rclk             (rclk)
        ,.rst_n            (rrst_n)
        ,.pwr              (pwr)
        ,.mem_on           (mem_on)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // ------------------------------------------------
    // Storage array
    // ------------------------------------------------

    // Isolation goes straight to the output clamp
    rf_8x178_array i_rf (
         .wclk    (wclk)
        ,.wrst_n  (wrst_n)
        ,.rclk    (rclk)
        ,.rrst_n  (rrst_n)
        ,.wr      (wr)
        ,.rd      (rd)
        ,.mem_on  (mem_on)
        ,.isol_en (pwr.isol_en)
        ,.rdata   (rdata)
    );

endmodule

`default_nettype wire

// ==== rf_8x178_array.sv ====
//------------------------------------------------
// Dual-clock 8x178 storage with valid column,
// power gating of writes and read isolation
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rf_8x178_array (
     input  logic                            wclk
    ,input  logic                            wrst_n
    ,input  logic                            rclk
    ,input  logic                            rrst_n
    ,input  mem_pkg::mem_wr_t                wr
    ,input  mem_pkg::mem_rd_t                rd
    ,input  logic                            mem_on
    ,input  logic                            isol_en
    ,output logic [mem_pkg::mem_data_w-1:0]  rdata
);

    import mem_pkg::*;

    // ------------------------------------------------
    // Write domain
    // ------------------------------------------------

    // mem_on comes from the rclk sequencer and is retimed into wclk
    logic [1:0]            mem_on_w_q;
    logic                  mem_on_w;

    // Data columns carry no reset, the valid column does
    logic [mem_data_w-1:0] data_q [mem_depth];
    logic [mem_depth-1:0]  valid_q;

    // Two-flop synchronizer for the power state
    // Resets high to match the sequencer, which leaves reset in PG_ON
    always_ff @(posedge wclk or negedge wrst_n) begin
        if (!wrst_n) begin
            mem_on_w_q <= 2'b11;
        end else begin
            mem_on_w_q <= {mem_on_w_q[0], mem_on};
        end
    end

    assign mem_on_w = mem_on_w_q[1];

    // Data write, a request while unpowered is simply lost
    always_ff @(posedge wclk) begin
        if (wr.en && mem_on_w) begin
            data_q[wr.addr] <= wr.data;
        end
    end

    // Valid column
    // A write sets its entry's bit at the same edge as the data.
    // While the array is unpowered all bits are held clear, which is
    // what marks the contents as lost across a power-gating cycle
    always_ff @(posedge wclk or negedge wrst_n) begin
        if (!wrst_n) begin
            valid_q <= '0;
        end else if (!mem_on_w) begin
            valid_q <= '0;
        end else if (wr.en) begin
            valid_q[wr.addr] <= 1'b1;
        end
    end

    // ------------------------------------------------
    // Read domain
    // ------------------------------------------------

    // Full stored word at the read address, valid bit on top
    logic [mem_word_w-1:0] rd_word;
    logic [mem_data_w-1:0] rdata_q;

    assign rd_word = {valid_q[rd.addr], data_q[rd.addr]};

    // Registered read, data appears one rclk edge after the strobe.
    // An entry without its valid bit reads back as zero.
    // The register holds between accepted reads and while unpowered
    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            rdata_q <= '0;
        end else if (rd.en && mem_on) begin
            if (rd_word[mem_word_w-1]) begin
                rdata_q <= rd_word[mem_data_w-1:0];
            end else begin
                rdata_q <= '0;
            end
        end
    end

    // Output clamp, isolation forces zero without touching the register
    always_comb begin
        if (isol_en) begin
            rdata = '0;
        end else begin
            rdata = rdata_q;
        end
    end

endmodule

`default_nettype wire

// ==== mem_pg_seq.sv ====
//------------------------------------------------
// Power-gate sequencer for the array power state
// and the delayed enable acknowledge
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mem_pg_seq (
     input  logic              rclk
    ,input  logic              rst_n
    ,input  pwr_pkg::pwr_ctl_t pwr
    ,output logic              mem_on
    ,output logic              pwr_enable_b_out
);

    import pwr_pkg::*;

    // ------------------------------------------------
    // State and delay counter
    // ------------------------------------------------

    pg_state_e             state_q;
    pg_state_e             state_d;
    logic [pg_cnt_w-1:0]   cnt_q;
    logic [pg_cnt_w-1:0]   cnt_d;

    // Next-state logic
    // The counter is loaded on entry to a transitional state
    // and the state moves on once it has run down to zero
    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        unique case (state_q)
            PG_ON: begin
                // Power-down request, array power goes away at once
                if (pwr.enable_b) begin
                    state_d = PG_DOWN;
                    cnt_d   = pg_cnt_w'(pg_ack_dly - 1);
                end
            end
            PG_DOWN: begin
                if (cnt_q == '0) begin
                    state_d = PG_OFF;
                end else begin
                    cnt_d = cnt_q - 1'b1;
                end
            end
            PG_OFF: begin
                // Wake request, power returns only after the delay
                if (!pwr.enable_b) begin
                    state_d = PG_UP;
                    cnt_d   = pg_cnt_w'(pg_ack_dly - 1);
                end
            end
            PG_UP: begin
                if (cnt_q == '0) begin
                    state_d = PG_ON;
                end else begin
                    cnt_d = cnt_q - 1'b1;
                end
            end
        endcase
    end

    // The block comes out of reset powered and acknowledged on
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= PG_ON;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // ------------------------------------------------
    // Outputs
    // ------------------------------------------------

    // Array is powered only in PG_ON, so mem_on drops on entering PG_DOWN
    // and rises pg_ack_dly cycles after a wake is sampled
    assign mem_on = (state_q == PG_ON);

    // Acknowledge is high from the end of power-down to the end of power-up
    assign pwr_enable_b_out = (state_q == PG_OFF) || (state_q == PG_UP);

endmodule

`default_nettype wire

// ==== mem_reset_sync.sv ====
//------------------------------------------------
// Reset synchronizer with scan bypass
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mem_reset_sync (
     input  logic clk
    ,input  logic arst_n
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b
    ,output logic rst_n_sync
);

    // Two-stage chain, a constant one shifts in after release
    logic [1:0] sync_q;

    // Assertion is immediate, release takes two clk edges
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // In scan mode the tester owns the reset directly
    // so the synchronizer flops are bypassed entirely
    always_comb begin
        if (fscan_rstbypen) begin
            rst_n_sync = fscan_byprst_b;
        end else begin
            rst_n_sync = sync_q[1];
        end
    end

endmodule

`default_nettype wire

// ==== pwr_pkg.sv ====
//------------------------------------------------
// Power-gate states, power-manager controls and
// the enable acknowledge delay
//------------------------------------------------
`default_nettype none

package pwr_pkg;

    // Array power state as seen by the sequencer
    // PG_DOWN and PG_UP are the timed transitional states
    typedef enum logic [1:0] {
        PG_ON   = 2'd0,
        PG_DOWN = 2'd1,
        PG_OFF  = 2'd2,
        PG_UP   = 2'd3
    } pg_state_e;

    // Controls from the power manager, both are levels
    typedef struct packed {
        logic isol_en;
        logic enable_b;
    } pwr_ctl_t;

    // ------------------------------------------------
    // Acknowledge timing
    // ------------------------------------------------

    // rclk cycles from a sampled change of enable_b to its acknowledge
    localparam int pg_ack_dly = 2;

    // Width of the transition down-counter
    localparam int pg_cnt_w = $clog2(pg_ack_dly + 1);

endpackage

`default_nettype wire

// ==== mem_pkg.sv ====
//------------------------------------------------
// Array geometry and the write and read request
// structs of the register file
//------------------------------------------------
`default_nettype none

package mem_pkg;

    // ------------------------------------------------
    // Geometry
    // ------------------------------------------------

    // Number of entries in the array
    localparam int mem_depth  = 8;
    localparam int mem_addr_w = 3;

    // User data width, the stored word adds one valid bit on top
    localparam int mem_data_w = 177;
    localparam int mem_word_w = mem_data_w + 1;

    // ------------------------------------------------
    // Requests
    // ------------------------------------------------

    // Write request on wclk, 181 bits
    typedef struct packed {
        logic                  en;
        logic [mem_addr_w-1:0] addr;
        logic [mem_data_w-1:0] data;
    } mem_wr_t;

    // Read request on rclk, 4 bits
    typedef struct packed {
        logic                  en;
        logic [mem_addr_w-1:0] addr;
    } mem_rd_t;

endpackage

`default_nettype wire
